// File: verilog.f
+incdir+.
stream_alu_pkg.sv
flow_if.sv
flow_reg_bypass.sv
cmd_decode.sv
alu_execute.sv
result_pack.sv
stream_alu_top.sv
tb_stream_alu.sv

// File: tb_stream_alu.sv
// Testbench for the stream ALU with LCG stimulus, a reference queue and assertion checks
`timescale 1ns/100ps
`include "stream_alu_cfg.svh"

module tb_stream_alu;

  localparam int DW = `STREAM_ALU_DW;
  localparam int SEQW = `STREAM_ALU_SEQW;
  localparam int CNTW = `STREAM_ALU_CNTW;
  localparam int CNT_MAX = (1 << CNTW) - 1;
  localparam logic [31:0] SEED = 32'h4770b6e0;
  // Commands per test phase
  localparam int N_REG = 28;
  localparam int N_IMM = 40;
  localparam int N_ILL = 300;
  localparam int N_RND = 200;
  localparam int N_CMDS = N_REG + N_IMM + N_ILL + N_RND;
  localparam int CYCLE_LIMIT = 4 * N_CMDS + 100;

  logic            clk;
  logic            arst_n;
  logic            cmd_valid;
  logic            cmd_ready;
  logic [31:0]     cmd_data;
  logic            res_valid;
  logic            res_ready;
  logic [DW-1:0]   res_data;
  logic [SEQW-1:0] res_seq;
  logic            res_err;
  logic [CNTW-1:0] illegal_count;

  logic [DW:0]     exp_q[$];
  logic [DW:0]     exp_item;
  logic [DW:0]     model_now;
  logic [SEQW-1:0] exp_seq = '0;
  logic [31:0]     cmd_rng;
  logic [31:0]     ready_rng;
  logic            no_stall = 1'b1;
  logic            rnd_ready = 1'b0;
  int              cycles = 0;
  int              results = 0;
  int              n_illegal = 0;
  int              err_values = 0;
  int              err_proto = 0;

  stream_alu_top dut (.*);

  // ------------------------------
  // Reference model and helpers
  // ------------------------------

  // Expected {err, result} worked out from the command word layout
  function automatic logic [DW:0] model_result(input logic [31:0] w);
    logic [2:0]    op;
    logic [DW-1:0] a;
    logic [DW-1:0] b;
    logic [DW-1:0] r;
    op = w[30:28];
    a  = DW'(w[27:14]);
    // Bit 31 selects immediate form, where b is imm shifted by shamt
    if (w[31]) begin
      b = DW'(w[9:0]) << w[13:10];
    end else begin
      b = DW'(w[13:0]);
    end
    case (op)
      3'd0:    r = a + b;
      3'd1:    r = a - b;
      3'd2:    r = a & b;
      3'd3:    r = a | b;
      3'd4:    r = a ^ b;
      3'd5:    r = a << b[3:0];
      3'd6:    r = a >> b[3:0];
      default: r = '0;
    endcase
    return {op == 3'd7, r};
  endfunction

  // Counter value after n illegal results, stuck at all ones once full
  function automatic logic [CNTW-1:0] saturated_count(input int n);
    return (n > CNT_MAX) ? CNTW'(CNT_MAX) : CNTW'(n);
  endfunction

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      err_values++;
      $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  // Holds the command until the DUT takes it on a rising edge
  task automatic send_cmd(input logic [31:0] word);
    cmd_valid <= 1'b1;
    cmd_data  <= word;
    @(posedge clk);
    while (!cmd_ready) @(posedge clk);
  endtask

  task automatic drain;
    cmd_valid <= 1'b0;
    @(posedge clk);
    while (exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
  endtask

  assign model_now = model_result(cmd_data);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit scales with the number of commands
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d results never came out", cycles, exp_q.size());
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Random back-pressure during the last phase, otherwise always ready
  always @(posedge clk) begin
    if (rnd_ready) begin
      ready_rng = lcg_step(ready_rng);
      res_ready <= ready_rng[31];
    end else begin
      res_ready <= 1'b1;
    end
  end

  // ------------------------------
  // Scoreboard
  // ------------------------------

  // Pop before push, a result never leaves in the cycle its command enters
  always @(posedge clk) begin
    if (arst_n) begin
      if (res_valid && res_ready) begin
        if (exp_q.size() == 0) begin
          err_proto++;
          $display("At %0t ns a result came out with no command outstanding", $time);
        end else begin
          exp_item = exp_q.pop_front();
          if (exp_item[DW]) begin
            n_illegal++;
          end
          check_value("res_data", exp_item[DW-1:0], res_data);
          check_value("res_err", exp_item[DW], res_err);
        end
        check_value("res_seq", exp_seq, res_seq);
        exp_seq = exp_seq + 1'b1;
        results++;
      end
      if (cmd_valid && cmd_ready) begin
        exp_q.push_back(model_now);
      end
    end
  end

  // ------------------------------
  // Protocol assertions
  // ------------------------------

  reset_state_a: assert property (@(posedge clk)
    $rose(arst_n) |-> !res_valid && cmd_ready && illegal_count == '0)
    else begin
      err_proto++;
      $display("At %0t ns the outputs were not in their reset state", $time);
    end

  // Stalled result must hold, so nothing is lost or repeated
  stall_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
    res_valid && !res_ready |=>
      res_valid && $stable(res_data) && $stable(res_seq) && $stable(res_err))
    else begin
      err_proto++;
      $display("At %0t ns a stalled result changed or vanished", $time);
    end

  illegal_zero_a: assert property (@(posedge clk) disable iff (!arst_n)
    res_valid && res_err |-> res_data == '0)
    else begin
      err_values++;
      $display("[ERROR] %0t ns res_data expected 0 got %0h", $time, $sampled(res_data));
    end

  // One step per expected illegal result that has left, sticking at all ones
  count_track_a: assert property (@(posedge clk) disable iff (!arst_n)
    illegal_count == saturated_count(n_illegal))
    else begin
      err_values++;
      $display("[ERROR] %0t ns illegal_count expected %0h got %0h", $time,
               saturated_count($sampled(n_illegal)), $sampled(illegal_count));
    end

  // Without back-pressure the result shows up one cycle after the accept
  latency_a: assert property (@(posedge clk) disable iff (!arst_n)
    no_stall && cmd_valid && cmd_ready |=> res_valid && {res_err, res_data} == $past(model_now))
    else begin
      err_proto++;
      $display("At %0t ns the result was not there one cycle after its command", $time);
    end

  // ------------------------------
  // Stimulus
  // ------------------------------

  initial begin
    arst_n    <= 1'b0;
    cmd_valid <= 1'b0;
    cmd_data  <= '0;
    res_ready <= 1'b1;
    cmd_rng   = SEED;
    ready_rng = lcg_step(SEED);
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    // Register form, opcodes 0 to 6 in turn, one command per cycle
    for (int i = 0; i < N_REG; i++) begin
      cmd_rng = lcg_step(cmd_rng);
      send_cmd({1'b0, 3'(i % 7), cmd_rng[27:0]});
    end
    // Immediate form with random legal opcodes
    for (int i = 0; i < N_IMM; i++) begin
      cmd_rng = lcg_step(cmd_rng);
      send_cmd({1'b1, cmd_rng[31:29] % 3'd7, cmd_rng[27:0]});
    end
    // Enough illegal commands in both forms to saturate the counter
    for (int i = 0; i < N_ILL; i++) begin
      cmd_rng = lcg_step(cmd_rng);
      send_cmd({cmd_rng[31], 3'd7, cmd_rng[27:0]});
    end
    drain();
    check_value("illegal_count", {CNTW{1'b1}}, illegal_count);
    no_stall  <= 1'b0;
    rnd_ready <= 1'b1;
    // Random words with idle gaps under random back-pressure
    for (int i = 0; i < N_RND; i++) begin
      cmd_rng = lcg_step(cmd_rng);
      if (cmd_rng[31:30] == 2'd0) begin
        cmd_valid <= 1'b0;
        @(posedge clk);
      end
      cmd_rng = lcg_step(cmd_rng);
      send_cmd(cmd_rng);
    end
    rnd_ready <= 1'b0;
    drain();
    $display("Run done: %0d results, %0d value errors, %0d protocol errors",
             results, err_values, err_proto);
    if (err_values == 0 && err_proto == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: stream_alu_top.sv
// Streaming command processor top with decode, execute and result stages
`timescale 1ns/100ps
`include "stream_alu_cfg.svh"

module stream_alu_top (
  input  logic                                          clk,
  input  logic                                          arst_n,
  // Command input
  input  logic                                          cmd_valid,
  output logic                                          cmd_ready,
  input  logic [$bits(stream_alu_pkg::cmd_word_u)-1:0] cmd_data,
  // Result output
  output logic                                          res_valid,
  input  logic                                          res_ready,
  output logic [`STREAM_ALU_DW-1:0]                     res_data,
  output logic [`STREAM_ALU_SEQW-1:0]                   res_seq,
  output logic                                          res_err,
  output logic [`STREAM_ALU_CNTW-1:0]                   illegal_count
);

  import stream_alu_pkg::*;

  // ------------------------------
  // Stage links
  // ------------------------------

  // Decoded operation from the decode buffer into execute
  flow_if #(.WIDTH($bits(dec_op_t))) dec_link ();

  // Raw ALU result from execute into the result stage
  flow_if #(.WIDTH(`STREAM_ALU_DW)) res_link ();

  // ------------------------------
  // Stages
  // ------------------------------

  // Decode is combinational with one parked entry under backpressure
  cmd_decode u_cmd_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_data  (cmd_data),
    .cmd_ready (cmd_ready),
    .dec       (dec_link.push)
  );

  // This register sets the one-cycle command to result latency
  alu_execute u_alu_execute (
    .clk     (clk),
    .arst_n  (arst_n),
    .op_in   (dec_link.pop),
    .res_out (res_link.push)
  );

  result_pack u_result_pack (
    .clk           (clk),
    .arst_n        (arst_n),
    .res_in        (res_link.pop),
    .res_ready     (res_ready),
    .res_valid     (res_valid),
    .res_data      (res_data),
    .res_seq       (res_seq),
    .res_err       (res_err),
    .illegal_count (illegal_count)
  );

endmodule

// File: result_pack.sv
// Result stage that numbers each result and keeps a saturating illegal count
`timescale 1ns/100ps
`include "stream_alu_cfg.svh"

module result_pack (
  input  logic                        clk,
  input  logic                        arst_n,
  flow_if.pop                         res_in,
  input  logic                        res_ready,
  output logic                        res_valid,
  output logic [`STREAM_ALU_DW-1:0]   res_data,
  output logic [`STREAM_ALU_SEQW-1:0] res_seq,
  output logic                        res_err,
  output logic [`STREAM_ALU_CNTW-1:0] illegal_count
);

  logic xfer;

  // ------------------------------
  // Pass-through data path
  // ------------------------------

  assign res_in.ready = res_ready;
  assign res_valid    = res_in.valid;
  assign res_data     = res_in.data;
  assign res_err      = res_in.err;

  assign xfer = res_in.valid && res_ready;

  // ------------------------------
  // Sequence and illegal counter
  // ------------------------------

  // Sequence number labels the result on the port and moves on after it leaves
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_seq       <= '0;
      illegal_count <= '0;
    end else if (xfer) begin
      res_seq <= res_seq + 1'b1;
      // Stick at all ones instead of wrapping
      if (res_in.err && illegal_count != '1) begin
        illegal_count <= illegal_count + 1'b1;
      end
    end
  end

  // Counter is monotonic between resets
  count_monotonic_a: assert property (@(posedge clk) disable iff (!arst_n)
    illegal_count >= $past(illegal_count));

endmodule

// File: alu_execute.sv
// ALU execute stage with a single registered result slot and ready-valid handshake
`timescale 1ns/100ps
`include "stream_alu_cfg.svh"

module alu_execute (
  input  logic clk,
  input  logic arst_n,
  flow_if.pop  op_in,
  flow_if.push res_out
);

  import stream_alu_pkg::*;

  localparam int DW = `STREAM_ALU_DW;

  dec_op_t       op_d;
  logic [DW-1:0] alu_res;
  logic          accept;
  logic          out_valid;
  logic [DW-1:0] res_q;
  logic          err_q;

  assign op_d = op_in.data;

  // ------------------------------
  // Combinational ALU
  // ------------------------------

  always_comb begin
    case (op_d.op)
      OP_ADD:  alu_res = op_d.a + op_d.b;
      OP_SUB:  alu_res = op_d.a - op_d.b;
      OP_AND:  alu_res = op_d.a & op_d.b;
      OP_OR:   alu_res = op_d.a | op_d.b;
      OP_XOR:  alu_res = op_d.a ^ op_d.b;
      OP_SHL:  alu_res = op_d.a << op_d.b[3:0];
      OP_SHR:  alu_res = op_d.a >> op_d.b[3:0];
      default: alu_res = '0;
    endcase
    // Illegal commands always report a zero result
    if (op_in.err) begin
      alu_res = '0;
    end
  end

  // ------------------------------
  // Result register
  // ------------------------------

  // Slot frees up in the same cycle it is drained, giving full throughput
  assign op_in.ready = !out_valid || res_out.ready;
  assign accept      = op_in.valid && op_in.ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (op_in.ready) begin
      out_valid <= op_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_q <= alu_res;
      err_q <= op_in.err;
    end
  end

  assign res_out.valid = out_valid;
  assign res_out.data  = res_q;
  assign res_out.err   = err_q;

  // A stalled result must not change until result_pack takes it
  out_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
    res_out.valid && !res_out.ready |=>
      res_out.valid && $stable(res_out.data) && $stable(res_out.err));

endmodule

// File: cmd_decode.sv
// Command decode stage that splits the command word into opcode and operands
`timescale 1ns/100ps
`include "stream_alu_cfg.svh"

module cmd_decode (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  cmd_valid,
  input  stream_alu_pkg::cmd_word_u cmd_data,
  output logic                  cmd_ready,
  flow_if.push                  dec
);

  import stream_alu_pkg::*;

  localparam int DW = `STREAM_ALU_DW;

  dec_op_t         dec_op;
  logic [DW-1:0]   imm_ext;

  // Decoded operation before the bypass buffer
  flow_if #(.WIDTH($bits(dec_op_t))) raw_if ();

  // ------------------------------
  // Field extraction
  // ------------------------------

  // Immediate widened first so the shift keeps the bits that spill past 10
  assign imm_ext = DW'(cmd_data.i.imm);

  always_comb begin
    // Op and a sit in the same place in both readings
    dec_op.op = cmd_data.r.op;
    dec_op.a  = DW'(cmd_data.r.a);
    if (cmd_data.r.form) begin
      // Immediate reading of the word
      dec_op.b = imm_ext << cmd_data.i.shamt;
    end else begin
      // Register reading of the word
      dec_op.b = DW'(cmd_data.r.b);
    end
  end

  // ------------------------------
  // Hand-off to the buffer
  // ------------------------------

  // Decode adds no latency, the handshake goes straight through
  assign raw_if.valid = cmd_valid;
  assign raw_if.data  = dec_op;
  assign raw_if.err   = (dec_op.op == OP_ILLEGAL);
  assign cmd_ready    = raw_if.ready;

  // Absorbs one command while execute is stalled
  flow_reg_bypass #(
    .WIDTH($bits(dec_op_t))
  ) u_dec_buf (
    .clk    (clk),
    .arst_n (arst_n),
    .push   (raw_if.pop),
    .pop    (dec)
  );

  // The form bit picks the layout, so an unknown there poisons everything downstream
  form_known_a: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_valid |-> !$isunknown(cmd_data.r.form));

endmodule

// File: flow_reg_bypass.sv
// Bypass flow register acting as a 1-entry FIFO with zero cut-through and backpressure delay
`timescale 1ns/100ps

module flow_reg_bypass #(
  parameter int WIDTH = 1
) (
  input logic  clk,
  input logic  arst_n,
  flow_if.pop  push,
  flow_if.push pop
);

  logic             pushed;
  logic             buf_push;
  logic             buf_pop;
  logic             buf_valid;
  logic             buf_valid_next;
  logic [WIDTH-1:0] buf_data;
  logic             buf_err;

  // ------------------------------
  // Buffer control
  // ------------------------------

  assign pushed = push.valid && push.ready;

  // An item lands in the skid buffer when the output stalls while empty
  // It also lands there when the buffer is full and draining, keeping order
  assign buf_push = pushed && (!pop.ready || buf_valid);
  assign buf_pop  = pop.ready && buf_valid;

  assign buf_valid_next = buf_push || (buf_valid && !buf_pop);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      buf_valid <= 1'b0;
    end else begin
      buf_valid <= buf_valid_next;
    end
  end

  // Payload of the parked entry
  always_ff @(posedge clk) begin
    if (buf_push) begin
      buf_data <= push.data;
      buf_err  <= push.err;
    end
  end

  // ------------------------------
  // Output muxing
  // ------------------------------

  // Ready comes straight from downstream unless an entry is parked
  assign push.ready = pop.ready || !buf_valid;

  // A parked entry always goes out before the live input
  assign pop.valid  = push.valid || buf_valid;
  assign pop.data   = buf_valid ? buf_data : push.data;
  assign pop.err    = buf_valid ? buf_err : push.err;

  // ------------------------------
  // Checks
  // ------------------------------

  // Must take a push on the first edge after reset is released
  ready_out_of_reset_a: assert property (@(posedge clk) $rose(arst_n) |-> push.ready);

  // An item offered to an empty register with downstream ready goes straight out
  valid_zero_delay_a: assert property (@(posedge clk) disable iff (!arst_n)
    push.valid && pop.ready && !buf_valid |=> !buf_valid);

  // With downstream ready and nothing arriving the buffer empties in that same cycle
  ready_zero_delay_a: assert property (@(posedge clk) disable iff (!arst_n)
    pop.ready && !push.valid |=> !buf_valid);

  // A parked item is what comes out on the next cycle
  buf_drives_output_a: assert property (@(posedge clk) disable iff (!arst_n)
    buf_push |=> pop.valid && pop.data == $past(push.data) && pop.err == $past(push.err));

endmodule

// File: flow_if.sv
// Ready-valid link carrying a payload and an illegal flag between pipeline stages
`timescale 1ns/100ps

interface flow_if #(
  parameter int WIDTH = 8
);

  // Handshake pair, a transfer happens when both are high on a rising edge
  logic             valid;
  logic             ready;

  // Payload and illegal flag travel together with valid
  // They must hold steady while valid is high and ready is low
  logic [WIDTH-1:0] data;
  logic             err;

  // ------------------------------
  // Views of the link
  // ------------------------------

  // Sender side drives valid, data and err
  modport push (
    output valid,
    output data,
    output err,
    input  ready
  );

  // Receiver side drives ready only
  modport pop (
    input  valid,
    input  data,
    input  err,
    output ready
  );

endinterface

// File: stream_alu_pkg.sv
// Stream ALU types for the opcodes, both command layouts and the decoded operation
`include "stream_alu_cfg.svh"

package stream_alu_pkg;

  // ------------------------------
  // Opcodes
  // ------------------------------

  // Shift amounts come from the low 4 bits of operand b
  typedef enum logic [2:0] {
    OP_ADD     = 3'd0,
    OP_SUB     = 3'd1,
    OP_AND     = 3'd2,
    OP_OR      = 3'd3,
    OP_XOR     = 3'd4,
    OP_SHL     = 3'd5,
    OP_SHR     = 3'd6,
    OP_ILLEGAL = 3'd7
  } alu_op_t;

  // ------------------------------
  // Command word layouts
  // ------------------------------

  // Register form, selected by form = 0
  // Both operands are 14 bits and get zero-extended in decode
  typedef struct packed {
    logic        form;
    alu_op_t     op;
    logic [13:0] a;
    logic [13:0] b;
  } reg_form_t;

  // Immediate form, selected by form = 1
  // Operand b is imm shifted left by shamt, cut to the data width
  typedef struct packed {
    logic        form;
    alu_op_t     op;
    logic [13:0] a;
    logic [3:0]  shamt;
    logic [9:0]  imm;
  } imm_form_t;

  // One 32-bit word read in either layout
  // The form bit and op field line up in both, so either view can select
  typedef union packed {
    reg_form_t r;
    imm_form_t i;
  } cmd_word_u;

  // ------------------------------
  // Decoded operation
  // ------------------------------

  // Operands are already at full width here, 35 bits in total
  typedef struct packed {
    alu_op_t                  op;
    logic [`STREAM_ALU_DW-1:0] a;
    logic [`STREAM_ALU_DW-1:0] b;
  } dec_op_t;

endpackage

// File: stream_alu_cfg.svh
// Stream ALU configuration with the operand, sequence and counter widths
`ifndef STREAM_ALU_CFG_SVH
`define STREAM_ALU_CFG_SVH

// ------------------------------
// Data path widths
// ------------------------------

// Width of operands a and b and of the ALU result
`define STREAM_ALU_DW 16

// Width of the sequence number attached to each result
// It wraps, so the testbench has to compare modulo this width
`define STREAM_ALU_SEQW 8

// ------------------------------
// Status widths
// ------------------------------

// Width of the illegal command counter, which saturates at all ones
`define STREAM_ALU_CNTW 8

`endif
